/* verilog/soc_bus_pkg.sv */
//----------------------------
// wishbone bus types
// address, data and byte select widths shared by the bus,
// the slaves and the testbench
//----------------------------

`default_nettype none

package soc_bus_pkg;

   // byte address as seen on the bus
   typedef logic [31:0] wb_adr_t;

   // one bus data word
   typedef logic [31:0] wb_dat_t;

   // one select bit per byte lane
   typedef logic [3:0] wb_sel_t;

endpackage : soc_bus_pkg

`default_nettype wire

/* verilog/soc_periph_pkg.sv */
//----------------------------
// peripheral address map
// region codes plus timer register layout and control bits
//----------------------------

`default_nettype none

package soc_periph_pkg;

   // ------------------------------
   // address map
   // ------------------------------

   // upper 16 address bits pick the region
   typedef logic [15:0] region_t;

   localparam region_t BRAM_REGION  = 16'h0000;
   localparam region_t TIMER_REGION = 16'hF001;

   // ------------------------------
   // timer registers
   // ------------------------------

   // word offsets inside one channel
   localparam int unsigned TMR_CTRL    = 0;
   localparam int unsigned TMR_COMPARE = 1;
   localparam int unsigned TMR_COUNTER = 2;

   // words from one channel to the next
   localparam int unsigned TMR_CH_STRIDE = 4;

   // control register bits
   // TR is sticky, cleared by writing 1
   localparam int unsigned TMR_TR_BIT    = 0;
   localparam int unsigned TMR_EN_BIT    = 1;
   localparam int unsigned TMR_AR_BIT    = 2;
   localparam int unsigned TMR_IRQEN_BIT = 3;

endpackage : soc_periph_pkg

`default_nettype wire

/* verilog/wb_decoder.sv */
//----------------------------
// wishbone address decoder
// routes stb to ram or timer by region, muxes the response
// and answers unmapped accesses itself
//----------------------------

`timescale 1ns/1ps
`default_nettype none

module wb_decoder
   import soc_bus_pkg::*;
   import soc_periph_pkg::*;
(
   input  wire     clk,
   input  wire     rst_n_i,
   // master side
   input  wb_adr_t wb_adr_i,
   input  wire     wb_cyc_i,
   input  wire     wb_stb_i,
   output wb_dat_t wb_dat_o,
   output logic    wb_ack_o,
   // block ram
   output logic    bram_stb_o,
   input  wb_dat_t bram_dat_i,
   input  wire     bram_ack_i,
   // timer
   output logic    tmr_stb_o,
   input  wb_dat_t tmr_dat_i,
   input  wire     tmr_ack_i
);

   region_t region;
   logic    bus_req;
   logic    bram_hit;
   logic    tmr_hit;
   logic    def_hit;
   logic    def_ack_q;

   // ------------------------------
   // region select
   // ------------------------------

   assign region   = wb_adr_i[31:16];
   assign bus_req  = wb_cyc_i & wb_stb_i;
   assign bram_hit = (region == BRAM_REGION);
   assign tmr_hit  = (region == TIMER_REGION);
   // nothing mapped here
   assign def_hit  = ~bram_hit & ~tmr_hit;

   // exactly one strobe at a time
   assign bram_stb_o = bus_req & bram_hit;
   assign tmr_stb_o  = bus_req & tmr_hit;

   // ------------------------------
   // default slave
   // ------------------------------

   // one ack per strobe, no side effects
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         def_ack_q <= 1'b0;
      end else begin
         def_ack_q <= bus_req & def_hit & ~def_ack_q;
      end
   end

   // ------------------------------
   // response mux
   // ------------------------------

   // only the addressed slave can ack
   assign wb_ack_o = bram_ack_i | tmr_ack_i | def_ack_q;

   // address is held until ack, so region still picks the source
   always_comb begin
      if (bram_hit) begin
         wb_dat_o = bram_dat_i;
      end else if (tmr_hit) begin
         wb_dat_o = tmr_dat_i;
      end else begin
         // unmapped reads return zero
         wb_dat_o = '0;
      end
   end

endmodule : wb_decoder

`default_nettype wire

/* verilog/wb_bram.sv */
//----------------------------
// block ram slave
// single port, byte select writes, one cycle ack
//----------------------------

`timescale 1ns/1ps
`default_nettype none

module wb_bram
   import soc_bus_pkg::*;
#(
   parameter int unsigned adr_w = 8
) (
   input  wire     clk,
   input  wire     rst_n_i,
   input  wire     stb_i,
   input  wire     we_i,
   input  wb_adr_t adr_i,
   input  wb_sel_t sel_i,
   input  wb_dat_t dat_i,
   output wb_dat_t dat_o,
   output logic    ack_o
);

   // word index into the array
   typedef logic [adr_w-1:0] bram_idx_t;

   wb_dat_t   mem_q [2**adr_w];
   bram_idx_t word_idx;
   logic      acc;

   // byte address to word address
   assign word_idx = adr_i[adr_w+1:2];

   // new strobe not yet answered
   assign acc = stb_i & ~ack_o;

   // ------------------------------
   // handshake
   // ------------------------------

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= acc;
      end
   end

   // ------------------------------
   // memory array
   // ------------------------------

   // write lands on the acking edge, read data comes with ack
   always_ff @(posedge clk) begin
      if (acc) begin
         dat_o <= mem_q[word_idx];
         if (we_i) begin
            for (int b = 0; b < 4; b++) begin
               // untouched lanes keep old contents
               if (sel_i[b]) begin
                  mem_q[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
               end
            end
         end
      end
   end

endmodule : wb_bram

`default_nettype wire

/* verilog/wb_timer.sv */
//----------------------------
// two channel microsecond timer
// compare match with one-shot or auto-reload
// and active low interrupt per channel
//----------------------------

`timescale 1ns/1ps
`default_nettype none

module wb_timer
   import soc_bus_pkg::*;
   import soc_periph_pkg::*;
#(
   parameter int unsigned clk_freq_hz = 50_000_000
) (
   input  wire        clk,
   input  wire        rst_n_i,
   input  wire        stb_i,
   input  wire        we_i,
   input  wb_adr_t    adr_i,
   input  wb_sel_t    sel_i,
   input  wb_dat_t    dat_i,
   output wb_dat_t    dat_o,
   output logic       ack_o,
   output logic [1:0] irq_n_o
);

   localparam int unsigned NUM_CH = 2;
   // clocks per microsecond, at least one
   localparam int unsigned PRESC_DIV =
      (clk_freq_hz >= 1_000_000) ? clk_freq_hz / 1_000_000 : 1;
   localparam int unsigned PRESC_W = (PRESC_DIV > 1) ? $clog2(PRESC_DIV) : 1;

   typedef logic [PRESC_W-1:0] presc_t;
   // control register, TR/EN/AR/IRQEN
   typedef logic [3:0] tmr_ctrl_t;
   // bus word index within the region
   typedef logic [13:0] tmr_word_t;
   typedef enum logic {
      ST_IDLE,
      ST_RUNNING
   } tmr_state_t;

   presc_t      presc_q;
   logic        us_tick;
   tmr_word_t   word_idx;
   tmr_word_t   ch_idx;
   tmr_word_t   reg_ofs;
   logic        acc;
   logic        wr_acc;
   logic        ofs_ctrl;
   logic        ofs_cmp;
   logic        ofs_cnt;
   logic [NUM_CH-1:0] ch_hit;
   logic [NUM_CH-1:0] match;
   logic [NUM_CH-1:0] count;
   tmr_ctrl_t   ctrl_q  [NUM_CH];
   wb_dat_t     cmp_q   [NUM_CH];
   wb_dat_t     cnt_q   [NUM_CH];
   tmr_state_t  state_q [NUM_CH];
   wb_dat_t     rd_val;

   // merge write data into a register under byte selects
   function automatic wb_dat_t merge_bytes(wb_dat_t old_val, wb_dat_t new_val,
                                           wb_sel_t sel);
      wb_dat_t res;
      res = old_val;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            res[8*b +: 8] = new_val[8*b +: 8];
         end
      end
      return res;
   endfunction

   // ------------------------------
   // microsecond prescaler
   // ------------------------------

   assign us_tick = (presc_q == presc_t'(PRESC_DIV - 1));

   // free running, shared by both channels
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         presc_q <= '0;
      end else if (us_tick) begin
         presc_q <= '0;
      end else begin
         presc_q <= presc_q + presc_t'(1);
      end
   end

   // ------------------------------
   // register decode
   // ------------------------------

   assign acc      = stb_i & ~ack_o;
   assign wr_acc   = acc & we_i;
   assign word_idx = adr_i[15:2];
   assign ch_idx   = tmr_word_t'(word_idx / TMR_CH_STRIDE);
   assign reg_ofs  = tmr_word_t'(word_idx % TMR_CH_STRIDE);
   assign ofs_ctrl = (reg_ofs == tmr_word_t'(TMR_CTRL));
   assign ofs_cmp  = (reg_ofs == tmr_word_t'(TMR_COMPARE));
   assign ofs_cnt  = (reg_ofs == tmr_word_t'(TMR_COUNTER));

   always_comb begin
      for (int n = 0; n < NUM_CH; n++) begin
         ch_hit[n] = (ch_idx == tmr_word_t'(n));
         // match checked on each tick while running
         match[n]  = (state_q[n] == ST_RUNNING) && ctrl_q[n][TMR_EN_BIT] && us_tick &&
                     (cnt_q[n] >= cmp_q[n]);
         count[n]  = (state_q[n] == ST_RUNNING) && ctrl_q[n][TMR_EN_BIT] && us_tick &&
                     !match[n];
      end
   end

   // ------------------------------
   // channel registers
   // ------------------------------

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int n = 0; n < NUM_CH; n++) begin
            ctrl_q[n]  <= '0;
            cmp_q[n]   <= '0;
            cnt_q[n]   <= '0;
            state_q[n] <= ST_IDLE;
         end
      end else begin
         for (int n = 0; n < NUM_CH; n++) begin
            // bus write to control, TR is write-one-to-clear
            if (wr_acc && ch_hit[n] && ofs_ctrl && sel_i[0]) begin
               ctrl_q[n][TMR_EN_BIT]    <= dat_i[TMR_EN_BIT];
               ctrl_q[n][TMR_AR_BIT]    <= dat_i[TMR_AR_BIT];
               ctrl_q[n][TMR_IRQEN_BIT] <= dat_i[TMR_IRQEN_BIT];
               if (dat_i[TMR_TR_BIT]) begin
                  ctrl_q[n][TMR_TR_BIT] <= 1'b0;
               end
            end
            // match comes last so its set beats a clear
            if (match[n]) begin
               ctrl_q[n][TMR_TR_BIT] <= 1'b1;
               if (!ctrl_q[n][TMR_AR_BIT]) begin
                  ctrl_q[n][TMR_EN_BIT] <= 1'b0;
               end
            end

            // counter: reload, hold or step
            if (match[n]) begin
               cnt_q[n] <= ctrl_q[n][TMR_AR_BIT] ? '0 : cmp_q[n];
            end else if (count[n]) begin
               cnt_q[n] <= cnt_q[n] + 32'd1;
            end
            if (wr_acc && ch_hit[n] && ofs_cnt) begin
               cnt_q[n] <= merge_bytes(cnt_q[n], dat_i, sel_i);
            end

            if (wr_acc && ch_hit[n] && ofs_cmp) begin
               cmp_q[n] <= merge_bytes(cmp_q[n], dat_i, sel_i);
            end

            // run state follows EN, one-shot match stops it
            case (state_q[n])
               ST_IDLE: begin
                  if (ctrl_q[n][TMR_EN_BIT]) begin
                     state_q[n] <= ST_RUNNING;
                  end
               end
               ST_RUNNING: begin
                  if (!ctrl_q[n][TMR_EN_BIT] ||
                      (match[n] && !ctrl_q[n][TMR_AR_BIT])) begin
                     state_q[n] <= ST_IDLE;
                  end
               end
               default: begin
                  state_q[n] <= ST_IDLE;
               end
            endcase
         end
      end
   end

   // ------------------------------
   // read path and handshake
   // ------------------------------

   always_comb begin
      rd_val = '0;
      for (int n = 0; n < NUM_CH; n++) begin
         if (ch_hit[n]) begin
            if (ofs_ctrl) begin
               rd_val = {28'd0, ctrl_q[n]};
            end else if (ofs_cmp) begin
               rd_val = cmp_q[n];
            end else if (ofs_cnt) begin
               rd_val = cnt_q[n];
            end
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= acc;
      end
   end

   // read data registered alongside ack
   always_ff @(posedge clk) begin
      if (acc) begin
         dat_o <= rd_val;
      end
   end

   // low while flag and enable are both set
   always_comb begin
      for (int n = 0; n < NUM_CH; n++) begin
         irq_n_o[n] = ~(ctrl_q[n][TMR_TR_BIT] & ctrl_q[n][TMR_IRQEN_BIT]);
      end
   end

endmodule : wb_timer

`default_nettype wire

/* verilog/soc_system.sv */
//----------------------------
// peripheral subsystem top
// one wishbone port into decoder, block ram and timer
//----------------------------

`timescale 1ns/1ps
`default_nettype none

module soc_system
   import soc_bus_pkg::*;
#(
   parameter int unsigned clk_freq_hz = 50_000_000,
   parameter int unsigned bram_adr_w  = 10
) (
   input  wire        clk,
   input  wire        rst_n_i,
   // bus master port
   input  wb_adr_t    wb_adr_i,
   input  wb_dat_t    wb_dat_i,
   input  wb_sel_t    wb_sel_i,
   input  wire        wb_we_i,
   input  wire        wb_cyc_i,
   input  wire        wb_stb_i,
   output wb_dat_t    wb_dat_o,
   output logic       wb_ack_o,
   // timer interrupts, active low
   output logic [1:0] timer_irq_n_o
);

   // slave strobes and responses
   logic    bram_stb;
   wb_dat_t bram_dat;
   logic    bram_ack;
   logic    tmr_stb;
   wb_dat_t tmr_dat;
   logic    tmr_ack;

   // ------------------------------
   // interconnect
   // ------------------------------

   wb_decoder i_decoder (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .wb_adr_i   (wb_adr_i),
      .wb_cyc_i   (wb_cyc_i),
      .wb_stb_i   (wb_stb_i),
      .wb_dat_o   (wb_dat_o),
      .wb_ack_o   (wb_ack_o),
      .bram_stb_o (bram_stb),
      .bram_dat_i (bram_dat),
      .bram_ack_i (bram_ack),
      .tmr_stb_o  (tmr_stb),
      .tmr_dat_i  (tmr_dat),
      .tmr_ack_i  (tmr_ack)
   );

   // ------------------------------
   // slaves
   // ------------------------------

   // address, data, sel and we shared by both
   wb_bram #(
      .adr_w (bram_adr_w)
   ) i_bram (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .stb_i   (bram_stb),
      .we_i    (wb_we_i),
      .adr_i   (wb_adr_i),
      .sel_i   (wb_sel_i),
      .dat_i   (wb_dat_i),
      .dat_o   (bram_dat),
      .ack_o   (bram_ack)
   );

   wb_timer #(
      .clk_freq_hz (clk_freq_hz)
   ) i_timer (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .stb_i   (tmr_stb),
      .we_i    (wb_we_i),
      .adr_i   (wb_adr_i),
      .sel_i   (wb_sel_i),
      .dat_i   (wb_dat_i),
      .dat_o   (tmr_dat),
      .ack_o   (tmr_ack),
      .irq_n_o (timer_irq_n_o)
   );

endmodule : soc_system

`default_nettype wire

/* dv/tb_checker.sv */
//----------------------------
// bus monitor and scoreboard
// shadows ram and compare registers, checks handshake
// timing and every predictable read
//----------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_checker
   import soc_bus_pkg::*;
   import soc_periph_pkg::*;
#(
   parameter int unsigned adr_w = 8
) (
   input  wire        clk,
   input  wire        rst_n_i,
   input  wb_adr_t    adr_i,
   input  wb_dat_t    wr_dat_i,
   input  wb_sel_t    sel_i,
   input  wire        we_i,
   input  wire        cyc_i,
   input  wire        stb_i,
   input  wb_dat_t    rd_dat_i,
   input  wire        ack_i,
   input  wire  [1:0] irq_n_i,
   output int         err_cnt_o
);

   wb_dat_t ram_sh  [2**adr_w];
   // bytes that have been written at least once
   wb_sel_t ram_vld [2**adr_w];
   wb_dat_t cmp_sh  [2];
   logic    exp_ack_q;

   initial begin
      err_cnt_o = 0;
      exp_ack_q = 1'b0;
      cmp_sh[0] = '0;
      cmp_sh[1] = '0;
      for (int i = 0; i < 2**adr_w; i++) begin
         ram_sh[i]  = '0;
         ram_vld[i] = '0;
      end
   end

   task automatic compare_value(input string name, input wb_dat_t exp_val,
                                input wb_dat_t act);
      if (act !== exp_val) begin
         err_cnt_o++;
         $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                  $time, name, exp_val, act);
      end
   endtask

   task automatic check_max(input string name, input wb_dat_t limit, input wb_dat_t act);
      if ($isunknown(act) || act > limit) begin
         err_cnt_o++;
         $display("CHECK FAILED time=%0t signal=%s expected<=%h actual=%h",
                  $time, name, limit, act);
      end
   endtask

   // compare register word of channel 0 or 1
   function automatic logic is_cmp(wb_adr_t adr);
      return adr[31:16] == TIMER_REGION && adr[15:2] / TMR_CH_STRIDE < 2 &&
             adr[15:2] % TMR_CH_STRIDE == TMR_COMPARE;
   endfunction

   // ------------------------------
   // reference model
   // ------------------------------

   // expected read data, unmapped space reads zero
   function automatic wb_dat_t ref_read(wb_adr_t adr);
      if (adr[31:16] == BRAM_REGION) begin
         return ram_sh[adr[adr_w+1:2]];
      end
      if (is_cmp(adr)) begin
         return cmp_sh[adr[15:2] / TMR_CH_STRIDE];
      end
      return '0;
   endfunction

   // lanes the model can predict
   // timer ctrl and counter move on their own
   function automatic wb_sel_t ref_mask(wb_adr_t adr);
      if (adr[31:16] == BRAM_REGION) begin
         return ram_vld[adr[adr_w+1:2]];
      end
      if (adr[31:16] == TIMER_REGION) begin
         return is_cmp(adr) ? 4'hF : 4'h0;
      end
      return 4'hF;
   endfunction

   // ------------------------------
   // monitor
   // ------------------------------

   // outputs idle while reset is held
   always @(negedge clk) begin
      if (!rst_n_i) begin
         compare_value("wb_ack_o", '0, 32'(ack_i));
         compare_value("timer_irq_n_o", 32'd3, 32'(irq_n_i));
      end
   end

   always @(posedge clk) begin : monitor
      wb_dat_t exp_dat;
      wb_sel_t msk;
      int      ch;
      if (!rst_n_i) begin
         exp_ack_q = 1'b0;
      end else begin
         // ack one cycle after a fresh strobe, never twice
         compare_value("wb_ack_o", 32'(exp_ack_q), 32'(ack_i));
         exp_ack_q = cyc_i & stb_i & ~ack_i;
         if (ack_i && cyc_i && stb_i && we_i) begin
            // shadow follows the acked write
            for (int b = 0; b < 4; b++) begin
               if (sel_i[b] && adr_i[31:16] == BRAM_REGION) begin
                  ram_sh[adr_i[adr_w+1:2]][8*b +: 8] = wr_dat_i[8*b +: 8];
                  ram_vld[adr_i[adr_w+1:2]][b] = 1'b1;
               end else if (sel_i[b] && is_cmp(adr_i)) begin
                  ch = adr_i[15:2] / TMR_CH_STRIDE;
                  cmp_sh[ch][8*b +: 8] = wr_dat_i[8*b +: 8];
               end
            end
         end else if (ack_i && cyc_i && stb_i) begin
            exp_dat = ref_read(adr_i);
            msk     = ref_mask(adr_i);
            for (int b = 0; b < 4; b++) begin
               if (msk[b]) begin
                  compare_value($sformatf("wb_dat_o[%0d:%0d] @%h", 8*b+7, 8*b, adr_i),
                                32'(exp_dat[8*b +: 8]), 32'(rd_dat_i[8*b +: 8]));
               end
            end
         end
      end
   end

endmodule : tb_checker

`default_nettype wire

/* dv/tb_system.sv */
//----------------------------
// system testbench
// stands in for the cpu as bus master, runs ram, decoder
// and timer tests, then reports status
//----------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_system
   import soc_bus_pkg::*;
   import soc_periph_pkg::*;
();

   // ------------------------------
   // test setup
   // ------------------------------

   localparam int unsigned CLK_FREQ_HZ = 4_000_000;
   localparam int unsigned BRAM_ADR_W  = 8;
   localparam int unsigned US_CYC      = CLK_FREQ_HZ / 1_000_000;
   localparam int unsigned N_WR        = 48;
   localparam int unsigned N_RD        = 24;
   // random ram traffic stays inside a few words
   localparam int unsigned POOL_W      = 4;
   localparam int unsigned CMP0        = 40;
   localparam int unsigned CMP1        = 10;
   localparam int unsigned ACK_LIMIT   = 16;
   localparam wb_adr_t     TMR_BASE    = 32'hF001_0000;
   // bus accesses take about 3 cycles, timers run compare+1 microseconds
   localparam int unsigned TEST_CYC =
      (N_WR + N_RD + 2**POOL_W + 2 * (CMP1 + 1) + 30) * 3 +
      (CMP0 + CMP1 + 2) * US_CYC * 2 + 20;
   localparam int unsigned WD_NS = (TEST_CYC * 4 + 400) * 8;

   localparam wb_dat_t CTRL_ONESHOT = (1 << TMR_EN_BIT) | (1 << TMR_IRQEN_BIT);
   localparam wb_dat_t CTRL_RELOAD  = (1 << TMR_EN_BIT) | (1 << TMR_AR_BIT);
   localparam wb_dat_t CTRL_TR_CLR  = (1 << TMR_TR_BIT) | (1 << TMR_IRQEN_BIT);

   logic        clk = 1'b0;
   logic        rst_n;
   wb_adr_t     wb_adr;
   wb_dat_t     wb_dat_w;
   wb_sel_t     wb_sel;
   logic        wb_we;
   logic        wb_cyc;
   logic        wb_stb;
   wb_dat_t     wb_dat_r;
   logic        wb_ack;
   logic [1:0]  irq_n;
   logic [31:0] lfsr_q;
   int          fail_cnt;
   int          chk_err;

   soc_system #(
      .clk_freq_hz (CLK_FREQ_HZ),
      .bram_adr_w  (BRAM_ADR_W)
   ) i_dut (
      .clk           (clk),
      .rst_n_i       (rst_n),
      .wb_adr_i      (wb_adr),
      .wb_dat_i      (wb_dat_w),
      .wb_sel_i      (wb_sel),
      .wb_we_i       (wb_we),
      .wb_cyc_i      (wb_cyc),
      .wb_stb_i      (wb_stb),
      .wb_dat_o      (wb_dat_r),
      .wb_ack_o      (wb_ack),
      .timer_irq_n_o (irq_n)
   );

   tb_checker #(
      .adr_w (BRAM_ADR_W)
   ) i_chk (
      .clk       (clk),
      .rst_n_i   (rst_n),
      .adr_i     (wb_adr),
      .wr_dat_i  (wb_dat_w),
      .sel_i     (wb_sel),
      .we_i      (wb_we),
      .cyc_i     (wb_cyc),
      .stb_i     (wb_stb),
      .rd_dat_i  (wb_dat_r),
      .ack_i     (wb_ack),
      .irq_n_i   (irq_n),
      .err_cnt_o (chk_err)
   );

   // 8 ns period
   initial begin
      forever #4 clk = ~clk;
   end

   // end the run if the tests stall
   initial begin
      #(WD_NS);
      $display("watchdog: tests did not finish within %0d ns", WD_NS);
      $display("STATUS: FAIL");
      $finish;
   end

   // ------------------------------
   // helpers
   // ------------------------------

   // 32 bit fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one lfsr step per bit taken
   task automatic take_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         val = {val[30:0], lfsr_q[0]};
      end
   endtask

   function automatic wb_adr_t ram_adr(int idx);
      return (wb_adr_t'(BRAM_REGION) << 16) | (wb_adr_t'(idx) << 2);
   endfunction

   function automatic wb_adr_t tmr_adr(int ch, int ofs);
      return TMR_BASE + wb_adr_t'((ch * TMR_CH_STRIDE + ofs) * 4);
   endfunction

   // single access, held until ack, then stb low for a cycle
   task automatic bus_access(input wb_adr_t adr, input logic we, input wb_dat_t dat,
                             input wb_sel_t sel, output wb_dat_t rd);
      int waited;
      waited = 0;
      @(posedge clk);
      wb_adr   <= adr;
      wb_dat_w <= dat;
      wb_sel   <= sel;
      wb_we    <= we;
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      @(posedge clk);
      while (!wb_ack && waited < ACK_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      if (!wb_ack) begin
         fail_cnt++;
         $display("bus: no ack for address %h at %0t", adr, $time);
      end
      rd = wb_dat_r;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic bus_write(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
      wb_dat_t unused;
      bus_access(adr, 1'b1, dat, sel, unused);
   endtask

   task automatic bus_read(input wb_adr_t adr, output wb_dat_t rd);
      bus_access(adr, 1'b0, '0, 4'hF, rd);
   endtask

   // ------------------------------
   // test sequence
   // ------------------------------

   initial begin
      wb_dat_t rd;
      wb_dat_t cnt;
      wb_dat_t prev;
      logic wrapped;
      logic [31:0] idx;
      logic [31:0] dat;
      logic [31:0] sel;
      int polls;
      rst_n    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      wb_sel   = '0;
      wb_we    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      fail_cnt = 0;
      lfsr_q   = 32'h832f;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      // random byte-select writes, then random reads
      for (int i = 0; i < N_WR; i++) begin
         take_bits(POOL_W, idx);
         take_bits(32, dat);
         take_bits(4, sel);
         bus_write(ram_adr(idx), dat, wb_sel_t'(sel));
      end
      for (int i = 0; i < N_RD; i++) begin
         take_bits(POOL_W, idx);
         bus_read(ram_adr(idx), rd);
      end

      // compare registers get known values
      bus_write(tmr_adr(0, TMR_COMPARE), CMP0, 4'hF);
      bus_write(tmr_adr(1, TMR_COMPARE), CMP1, 4'hF);

      // unmapped accesses, low bits alias ram and timer words
      bus_read(32'h0001_0004, rd);
      bus_read(32'h5A5A_1234, rd);
      bus_write(32'h0001_0004, 32'hDEAD_BEEF, 4'hF);
      bus_write(32'hF002_0004, 32'hDEAD_BEEF, 4'hF);
      bus_write(32'hF000_0014, 32'hDEAD_BEEF, 4'hF);
      for (int i = 0; i < 2**POOL_W; i++) begin
         bus_read(ram_adr(i), rd);
      end
      bus_read(tmr_adr(0, TMR_COMPARE), rd);
      bus_read(tmr_adr(1, TMR_COMPARE), rd);

      // channel 0, one-shot with interrupt
      bus_write(tmr_adr(0, TMR_CTRL), CTRL_ONESHOT, 4'h1);
      polls = 0;
      rd = '0;
      while (!rd[TMR_TR_BIT] && polls < (CMP0 + 1) * US_CYC) begin
         bus_read(tmr_adr(0, TMR_CTRL), rd);
         polls++;
      end
      if (!rd[TMR_TR_BIT]) begin
         fail_cnt++;
         $display("timer channel 0 never flagged its compare match");
      end
      i_chk.compare_value("ch0 ctrl EN", '0, 32'(rd[TMR_EN_BIT]));
      i_chk.compare_value("timer_irq_n_o[0]", '0, 32'(irq_n[0]));
      bus_read(tmr_adr(0, TMR_COUNTER), rd);
      i_chk.compare_value("ch0 counter", CMP0, rd);
      bus_write(tmr_adr(0, TMR_CTRL), CTRL_TR_CLR, 4'h1);
      i_chk.compare_value("timer_irq_n_o[0]", 32'd1, 32'(irq_n[0]));

      // channel 1, auto-reload without interrupt
      bus_write(tmr_adr(1, TMR_CTRL), CTRL_RELOAD, 4'h1);
      polls = 0;
      rd = '0;
      while (!rd[TMR_TR_BIT] && polls < (CMP1 + 1) * US_CYC) begin
         bus_read(tmr_adr(1, TMR_COUNTER), cnt);
         i_chk.check_max("ch1 counter", CMP1, cnt);
         i_chk.compare_value("timer_irq_n_o[1]", 32'd1, 32'(irq_n[1]));
         bus_read(tmr_adr(1, TMR_CTRL), rd);
         polls++;
      end
      if (!rd[TMR_TR_BIT]) begin
         fail_cnt++;
         $display("timer channel 1 never flagged its compare match");
      end

      // keep sampling past the match, the counter must drop back
      wrapped = 1'b0;
      for (int i = 0; i < 2 * (CMP1 + 1); i++) begin
         prev = cnt;
         bus_read(tmr_adr(1, TMR_COUNTER), cnt);
         i_chk.check_max("ch1 counter", CMP1, cnt);
         i_chk.compare_value("timer_irq_n_o[1]", 32'd1, 32'(irq_n[1]));
         if (cnt < prev) begin
            wrapped = 1'b1;
         end
      end
      if (!wrapped) begin
         fail_cnt++;
         $display("timer channel 1 counter never restarted after a match");
      end
      i_chk.compare_value("timer_irq_n_o[1]", 32'd1, 32'(irq_n[1]));

      // channel 0 left alone by channel 1
      bus_read(tmr_adr(0, TMR_CTRL), rd);
      i_chk.compare_value("ch0 ctrl", 32'(1 << TMR_IRQEN_BIT), rd);
      bus_read(tmr_adr(0, TMR_COUNTER), rd);
      i_chk.compare_value("ch0 counter", CMP0, rd);
      bus_read(tmr_adr(0, TMR_COMPARE), rd);
      i_chk.compare_value("timer_irq_n_o[0]", 32'd1, 32'(irq_n[0]));

      repeat (2) @(posedge clk);
      $display("errors: check=%0d other=%0d", chk_err, fail_cnt);
      if (chk_err == 0 && fail_cnt == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule : tb_system

`default_nettype wire

/* compile.f */
verilog/soc_bus_pkg.sv
verilog/soc_periph_pkg.sv
verilog/wb_decoder.sv
verilog/wb_bram.sv
verilog/wb_timer.sv
verilog/soc_system.sv
dv/tb_checker.sv
dv/tb_system.sv
